//--- hdl/mult_config.svh
`ifndef MULT_CONFIG_SVH
`define MULT_CONFIG_SVH

// ------------------------------
// Datapath widths
// ------------------------------

// Operand and result word
`define MULT_XLEN 64

// Operand with extension bit on top
`define MULT_OPW 65

// Full signed product of two widened operands
`define MULT_PRODW 130

// Physical register tag
`define MULT_PREGW 7

`endif

//--- hdl/mult_pkg.sv
`include "mult_config.svh"

package mult_pkg;

  // ------------------------------
  // Width types
  // ------------------------------
  typedef logic [`MULT_XLEN-1:0]  xlen_t;
  typedef logic [`MULT_OPW-1:0]   opnd_t;
  typedef logic [`MULT_PRODW-1:0] prod_t;
  typedef logic [`MULT_PREGW-1:0] preg_t;

  // ------------------------------
  // Operation and result select
  // ------------------------------
  typedef enum logic [2:0] {
    MULT_MUL    = 3'd0,
    MULT_MULH   = 3'd1,
    MULT_MULHU  = 3'd2,
    MULT_MULHSU = 3'd3,
    MULT_MULW   = 3'd4
  } mult_op_e;

  // Which part of the EX4 product goes onto the result bus
  typedef enum logic [1:0] {
    RSLT_LO   = 2'd0,
    RSLT_HI   = 2'd1,
    RSLT_WORD = 2'd2
  } rslt_sel_e;

endpackage

//--- hdl/mult_issue_stage.sv
`timescale 1ns/100ps
`include "mult_config.svh"

module mult_issue_stage (
  input  logic                mult_clk,
  input  logic                cpurst_b,
  input  logic                issue_vld,
  input  mult_pkg::mult_op_e  issue_op,
  input  mult_pkg::xlen_t     issue_src0,
  input  mult_pkg::xlen_t     issue_src1,
  input  mult_pkg::preg_t     issue_dst_preg,
  output mult_pkg::opnd_t     ex1_src0,
  output mult_pkg::opnd_t     ex1_src1,
  output mult_pkg::rslt_sel_e ex1_rslt_sel,
  output mult_pkg::preg_t     ex1_dst_preg
);

  logic                src0_signed;
  logic                src1_signed;
  logic                word_op;
  mult_pkg::rslt_sel_e rf_rslt_sel;
  mult_pkg::xlen_t     rf_src0_word;
  mult_pkg::xlen_t     rf_src1_word;
  mult_pkg::opnd_t     rf_src0;
  mult_pkg::opnd_t     rf_src1;

  // ------------------------------
  // RF stage operation decode
  // ------------------------------
  always_comb begin
    src0_signed = 1'b1;
    src1_signed = 1'b1;
    word_op     = 1'b0;
    rf_rslt_sel = mult_pkg::RSLT_HI;
    case (issue_op)
      mult_pkg::MULT_MUL: begin
        rf_rslt_sel = mult_pkg::RSLT_LO;
      end
      mult_pkg::MULT_MULH: begin
        rf_rslt_sel = mult_pkg::RSLT_HI;
      end
      mult_pkg::MULT_MULHU: begin
        src0_signed = 1'b0;
        src1_signed = 1'b0;
      end
      mult_pkg::MULT_MULHSU: begin
        src1_signed = 1'b0;
      end
      mult_pkg::MULT_MULW: begin
        word_op     = 1'b1;
        rf_rslt_sel = mult_pkg::RSLT_WORD;
      end
      default: begin
        rf_rslt_sel = mult_pkg::RSLT_LO;
      end
    endcase
  end

  // Upper word dropped for mulw, low 32 product bits do not depend on it
  assign rf_src0_word = word_op ? {{(`MULT_XLEN-32){1'b0}}, issue_src0[31:0]} : issue_src0;
  assign rf_src1_word = word_op ? {{(`MULT_XLEN-32){1'b0}}, issue_src1[31:0]} : issue_src1;

  // Widen to 65 bits, extension bit is the sign or zero
  assign rf_src0 = {src0_signed & rf_src0_word[`MULT_XLEN-1], rf_src0_word};
  assign rf_src1 = {src1_signed & rf_src1_word[`MULT_XLEN-1], rf_src1_word};

  // ------------------------------
  // EX1 operand registers
  // ------------------------------
  always_ff @(posedge mult_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      ex1_src0     <= '0;
      ex1_src1     <= '0;
      ex1_rslt_sel <= mult_pkg::RSLT_LO;
      ex1_dst_preg <= '0;
    end else if (issue_vld) begin
      ex1_src0     <= rf_src0;
      ex1_src1     <= rf_src1;
      ex1_rslt_sel <= rf_rslt_sel;
      ex1_dst_preg <= issue_dst_preg;
    end
  end

endmodule

//--- hdl/mult_booth_array.sv
`timescale 1ns/100ps
`include "mult_config.svh"

module mult_booth_array (
  input  logic            mult_clk,
  input  logic            cpurst_b,
  input  logic            ex1_vld,
  input  logic            ex2_vld,
  input  mult_pkg::opnd_t ex1_src0,
  input  mult_pkg::opnd_t ex1_src1,
  output mult_pkg::prod_t ex3_product
);

  // Multiplier split at bit 33, low part unsigned, high part signed
  logic signed [`MULT_OPW+33:0] ex1_pp_lo;
  logic signed [`MULT_OPW+31:0] ex1_pp_hi;
  logic signed [`MULT_OPW+33:0] ex2_pp_lo;
  logic signed [`MULT_OPW+31:0] ex2_pp_hi;
  mult_pkg::prod_t              ex2_pp_lo_ext;
  mult_pkg::prod_t              ex2_pp_hi_shft;
  mult_pkg::prod_t              ex2_sum;

  // ------------------------------
  // EX1 partial products
  // ------------------------------
  // Zero on top keeps the low 33 multiplier bits unsigned
  assign ex1_pp_lo = $signed(ex1_src0) * $signed({1'b0, ex1_src1[32:0]});
  assign ex1_pp_hi = $signed(ex1_src0) * $signed(ex1_src1[`MULT_OPW-1:33]);

  always_ff @(posedge mult_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      ex2_pp_lo <= '0;
      ex2_pp_hi <= '0;
    end else if (ex1_vld) begin
      ex2_pp_lo <= ex1_pp_lo;
      ex2_pp_hi <= ex1_pp_hi;
    end
  end

  // ------------------------------
  // EX2 final add
  // ------------------------------
  assign ex2_pp_lo_ext  = {{(`MULT_PRODW-`MULT_OPW-34){ex2_pp_lo[`MULT_OPW+33]}}, ex2_pp_lo};
  // Upper partial product weighs 2^33
  assign ex2_pp_hi_shft = {ex2_pp_hi, 33'b0};
  assign ex2_sum        = ex2_pp_lo_ext + ex2_pp_hi_shft;

  always_ff @(posedge mult_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      ex3_product <= '0;
    end else if (ex2_vld) begin
      ex3_product <= ex2_sum;
    end
  end

endmodule

//--- hdl/mult_pipe_ctrl.sv
`timescale 1ns/100ps

module mult_pipe_ctrl (
  input  logic                mult_clk,
  input  logic                cpurst_b,
  input  logic                issue_vld,
  input  logic                flush,
  input  mult_pkg::rslt_sel_e ex1_rslt_sel,
  input  mult_pkg::preg_t     ex1_dst_preg,
  output logic                ex1_vld,
  output logic                ex2_vld,
  output logic                ex3_vld,
  output logic                ex1_stall,
  output logic                ex2_wakeup_vld,
  output mult_pkg::preg_t     ex2_wakeup_preg,
  output logic                ex3_data_vld,
  output mult_pkg::preg_t     ex3_preg,
  output logic                ex4_data_vld,
  output mult_pkg::rslt_sel_e ex4_rslt_sel
);

  mult_pkg::rslt_sel_e ex2_rslt_sel;
  mult_pkg::rslt_sel_e ex3_rslt_sel;
  // EX4 tag follows the result onto the bus
  mult_pkg::preg_t     ex4_preg;

  // ------------------------------
  // Valid chain
  // ------------------------------
  // Flush also kills an instruction issued at the same edge
  always_ff @(posedge mult_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      ex1_vld      <= 1'b0;
      ex2_vld      <= 1'b0;
      ex3_vld      <= 1'b0;
      ex4_data_vld <= 1'b0;
    end else if (flush) begin
      ex1_vld      <= 1'b0;
      ex2_vld      <= 1'b0;
      ex3_vld      <= 1'b0;
      ex4_data_vld <= 1'b0;
    end else begin
      ex1_vld      <= issue_vld;
      ex2_vld      <= ex1_vld;
      ex3_vld      <= ex2_vld;
      ex4_data_vld <= ex3_vld;
    end
  end

  // Hold issue while EX1 is busy
  assign ex1_stall      = ex1_vld;
  assign ex2_wakeup_vld = ex2_vld;
  assign ex3_data_vld   = ex3_vld;

  // ------------------------------
  // Tag and select per stage
  // ------------------------------
  always_ff @(posedge mult_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      ex2_wakeup_preg <= '0;
      ex2_rslt_sel    <= mult_pkg::RSLT_LO;
    end else if (ex1_vld) begin
      ex2_wakeup_preg <= ex1_dst_preg;
      ex2_rslt_sel    <= ex1_rslt_sel;
    end
  end

  always_ff @(posedge mult_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      ex3_preg     <= '0;
      ex3_rslt_sel <= mult_pkg::RSLT_LO;
    end else if (ex2_vld) begin
      ex3_preg     <= ex2_wakeup_preg;
      ex3_rslt_sel <= ex2_rslt_sel;
    end
  end

  always_ff @(posedge mult_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      ex4_preg     <= '0;
      ex4_rslt_sel <= mult_pkg::RSLT_LO;
    end else if (ex3_vld) begin
      ex4_preg     <= ex3_preg;
      ex4_rslt_sel <= ex3_rslt_sel;
    end
  end

endmodule

//--- hdl/mult_result_sel.sv
`timescale 1ns/100ps
`include "mult_config.svh"

module mult_result_sel (
  input  logic                mult_clk,
  input  logic                cpurst_b,
  input  logic                ex3_vld,
  input  mult_pkg::prod_t     ex3_product,
  input  mult_pkg::rslt_sel_e ex4_rslt_sel,
  output mult_pkg::xlen_t     ex4_data
);

  // Top two product bits are only sign copies
  logic [2*`MULT_XLEN-1:0] ex4_product;

  always_ff @(posedge mult_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      ex4_product <= '0;
    end else if (ex3_vld) begin
      ex4_product <= ex3_product[2*`MULT_XLEN-1:0];
    end
  end

  // ------------------------------
  // Result bus select
  // ------------------------------
  always_comb begin
    case (ex4_rslt_sel)
      mult_pkg::RSLT_HI:   ex4_data = ex4_product[2*`MULT_XLEN-1:`MULT_XLEN];
      mult_pkg::RSLT_WORD: ex4_data = {{(`MULT_XLEN-32){ex4_product[31]}}, ex4_product[31:0]};
      default:             ex4_data = ex4_product[`MULT_XLEN-1:0];
    endcase
  end

endmodule

//--- hdl/mult_unit.sv
`timescale 1ns/100ps

module mult_unit (
  input  logic               mult_clk,
  input  logic               cpurst_b,
  input  logic               issue_vld,
  input  mult_pkg::mult_op_e issue_op,
  input  mult_pkg::xlen_t    issue_src0,
  input  mult_pkg::xlen_t    issue_src1,
  input  mult_pkg::preg_t    issue_dst_preg,
  input  logic               flush,
  output logic               ex1_stall,
  output logic               ex2_wakeup_vld,
  output mult_pkg::preg_t    ex2_wakeup_preg,
  output logic               ex3_data_vld,
  output mult_pkg::preg_t    ex3_preg,
  output logic               ex4_data_vld,
  output mult_pkg::xlen_t    ex4_data
);

  mult_pkg::opnd_t     ex1_src0;
  mult_pkg::opnd_t     ex1_src1;
  mult_pkg::rslt_sel_e ex1_rslt_sel;
  mult_pkg::preg_t     ex1_dst_preg;
  logic                ex1_vld;
  logic                ex2_vld;
  logic                ex3_vld;
  mult_pkg::prod_t     ex3_product;
  mult_pkg::rslt_sel_e ex4_rslt_sel;

  // ------------------------------
  // RF and EX1 operands
  // ------------------------------
  mult_issue_stage i_issue_stage (
    .mult_clk       (mult_clk),
    .cpurst_b       (cpurst_b),
    .issue_vld      (issue_vld),
    .issue_op       (issue_op),
    .issue_src0     (issue_src0),
    .issue_src1     (issue_src1),
    .issue_dst_preg (issue_dst_preg),
    .ex1_src0       (ex1_src0),
    .ex1_src1       (ex1_src1),
    .ex1_rslt_sel   (ex1_rslt_sel),
    .ex1_dst_preg   (ex1_dst_preg)
  );

  // Valids, tags and selects for all stages
  mult_pipe_ctrl i_pipe_ctrl (
    .mult_clk        (mult_clk),
    .cpurst_b        (cpurst_b),
    .issue_vld       (issue_vld),
    .flush           (flush),
    .ex1_rslt_sel    (ex1_rslt_sel),
    .ex1_dst_preg    (ex1_dst_preg),
    .ex1_vld         (ex1_vld),
    .ex2_vld         (ex2_vld),
    .ex3_vld         (ex3_vld),
    .ex1_stall       (ex1_stall),
    .ex2_wakeup_vld  (ex2_wakeup_vld),
    .ex2_wakeup_preg (ex2_wakeup_preg),
    .ex3_data_vld    (ex3_data_vld),
    .ex3_preg        (ex3_preg),
    .ex4_data_vld    (ex4_data_vld),
    .ex4_rslt_sel    (ex4_rslt_sel)
  );

  // ------------------------------
  // Multiplier and EX4 select
  // ------------------------------
  mult_booth_array i_booth_array (
    .mult_clk    (mult_clk),
    .cpurst_b    (cpurst_b),
    .ex1_vld     (ex1_vld),
    .ex2_vld     (ex2_vld),
    .ex1_src0    (ex1_src0),
    .ex1_src1    (ex1_src1),
    .ex3_product (ex3_product)
  );

  mult_result_sel i_result_sel (
    .mult_clk     (mult_clk),
    .cpurst_b     (cpurst_b),
    .ex3_vld      (ex3_vld),
    .ex3_product  (ex3_product),
    .ex4_rslt_sel (ex4_rslt_sel),
    .ex4_data     (ex4_data)
  );

endmodule

//--- testbench/mult_unit_asserts.sv
`timescale 1ns/100ps

module mult_unit_asserts (
  input logic            mult_clk,
  input logic            cpurst_b,
  input logic            issue_vld,
  input mult_pkg::preg_t issue_dst_preg,
  input logic            flush,
  input logic            ex1_stall,
  input logic            ex2_wakeup_vld,
  input mult_pkg::preg_t ex2_wakeup_preg,
  input logic            ex3_data_vld,
  input mult_pkg::preg_t ex3_preg,
  input logic            ex4_data_vld,
  input mult_pkg::preg_t ex4_preg
);

  // Number of failed checks
  int fail_cnt = 0;

  // ------------------------------
  // Stage timing and tags
  // ------------------------------
  a_ex1_stall: assert property (@(posedge mult_clk) disable iff (!cpurst_b)
    $past(issue_vld) && !$past(flush) |-> ex1_stall)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("ex1_stall low one cycle after issue");
    end

  // Stall only ever follows an issue
  a_stall_src: assert property (@(posedge mult_clk) disable iff (!cpurst_b)
    ex1_stall |-> $past(issue_vld))
    else begin
      fail_cnt = fail_cnt + 1;
      $error("ex1_stall high without an issue");
    end

  a_ex2_wakeup: assert property (@(posedge mult_clk) disable iff (!cpurst_b)
    $past(issue_vld, 2) && !$past(flush, 2) && !$past(flush)
    |-> ex2_wakeup_vld && (ex2_wakeup_preg == $past(issue_dst_preg, 2)))
    else begin
      fail_cnt = fail_cnt + 1;
      $error("EX2 wake-up missing or tag wrong two cycles after issue");
    end

  a_ex3_data: assert property (@(posedge mult_clk) disable iff (!cpurst_b)
    $past(issue_vld, 3) && !$past(flush, 3) && !$past(flush, 2) && !$past(flush)
    |-> ex3_data_vld && (ex3_preg == $past(issue_dst_preg, 3)))
    else begin
      fail_cnt = fail_cnt + 1;
      $error("EX3 valid missing or tag wrong three cycles after issue");
    end

  a_ex4_data: assert property (@(posedge mult_clk) disable iff (!cpurst_b)
    $past(issue_vld, 4) && !$past(flush, 4) && !$past(flush, 3) && !$past(flush, 2)
    && !$past(flush) |-> ex4_data_vld && (ex4_preg == $past(issue_dst_preg, 4)))
    else begin
      fail_cnt = fail_cnt + 1;
      $error("EX4 valid missing or tag wrong four cycles after issue");
    end

  // ------------------------------
  // Flush and reset
  // ------------------------------
  a_flush_clear: assert property (@(posedge mult_clk) disable iff (!cpurst_b)
    $past(flush) |-> !ex1_stall && !ex2_wakeup_vld && !ex3_data_vld && !ex4_data_vld)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("valid output still high the cycle after flush");
    end

  a_reset_quiet: assert property (@(posedge mult_clk)
    !cpurst_b || $past(!cpurst_b)
    |-> !ex1_stall && !ex2_wakeup_vld && !ex3_data_vld && !ex4_data_vld)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("valid output high during or just after reset");
    end

endmodule

bind mult_unit mult_unit_asserts i_mult_unit_asserts (
  .mult_clk        (mult_clk),
  .cpurst_b        (cpurst_b),
  .issue_vld       (issue_vld),
  .issue_dst_preg  (issue_dst_preg),
  .flush           (flush),
  .ex1_stall       (ex1_stall),
  .ex2_wakeup_vld  (ex2_wakeup_vld),
  .ex2_wakeup_preg (ex2_wakeup_preg),
  .ex3_data_vld    (ex3_data_vld),
  .ex3_preg        (ex3_preg),
  .ex4_data_vld    (ex4_data_vld),
  .ex4_preg        (i_pipe_ctrl.ex4_preg)
);

//--- testbench/mult_unit_tb.sv
`timescale 1ns/100ps
`include "mult_config.svh"

module mult_unit_tb;

  logic                mult_clk;
  logic                cpurst_b;
  logic                issue_vld;
  mult_pkg::mult_op_e  issue_op;
  mult_pkg::xlen_t     issue_src0;
  mult_pkg::xlen_t     issue_src1;
  mult_pkg::preg_t     issue_dst_preg;
  logic                flush;
  logic                ex1_stall;
  logic                ex2_wakeup_vld;
  mult_pkg::preg_t     ex2_wakeup_preg;
  logic                ex3_data_vld;
  mult_pkg::preg_t     ex3_preg;
  logic                ex4_data_vld;
  mult_pkg::xlen_t     ex4_data;

  logic [31:0]         rng_state;
  int                  issue_cnt;
  // Expected results in issue order
  mult_pkg::xlen_t     exp_q[$];

  mult_unit i_mult_unit (
    .mult_clk        (mult_clk),
    .cpurst_b        (cpurst_b),
    .issue_vld       (issue_vld),
    .issue_op        (issue_op),
    .issue_src0      (issue_src0),
    .issue_src1      (issue_src1),
    .issue_dst_preg  (issue_dst_preg),
    .flush           (flush),
    .ex1_stall       (ex1_stall),
    .ex2_wakeup_vld  (ex2_wakeup_vld),
    .ex2_wakeup_preg (ex2_wakeup_preg),
    .ex3_data_vld    (ex3_data_vld),
    .ex3_preg        (ex3_preg),
    .ex4_data_vld    (ex4_data_vld),
    .ex4_data        (ex4_data)
  );

  always #5 mult_clk = ~mult_clk;

  // ------------------------------
  // Stimulus helpers
  // ------------------------------
  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1103515245 + 32'd12345;
    return rng_state;
  endfunction

  function automatic mult_pkg::xlen_t pick_operand();
    logic [31:0]     rnd;
    mult_pkg::xlen_t val;
    rnd = next_rand();
    // About one operand in three is a corner value
    if (rnd[31:28] < 4'd5) begin
      case (rnd[27:25])
        3'd0:    val = '0;
        3'd1:    val = '1;
        3'd2:    val = 64'h8000_0000_0000_0000;
        3'd3:    val = 64'h7fff_ffff_ffff_ffff;
        3'd4:    val = 64'h0000_0000_8000_0000;
        3'd5:    val = 64'h0000_0000_7fff_ffff;
        3'd6:    val = 64'hffff_ffff_8000_0000;
        default: val = 64'h0000_0000_ffff_ffff;
      endcase
    end else begin
      val = {next_rand(), next_rand()};
    end
    return val;
  endfunction

  // Reference result from 128-bit products of extended operands
  function automatic mult_pkg::xlen_t model_result(mult_pkg::mult_op_e op,
                                                   mult_pkg::xlen_t a,
                                                   mult_pkg::xlen_t b);
    logic [2*`MULT_XLEN-1:0] a_s;
    logic [2*`MULT_XLEN-1:0] a_u;
    logic [2*`MULT_XLEN-1:0] b_s;
    logic [2*`MULT_XLEN-1:0] b_u;
    logic [2*`MULT_XLEN-1:0] prod;
    mult_pkg::xlen_t         res;
    a_s = {{`MULT_XLEN{a[`MULT_XLEN-1]}}, a};
    a_u = {{`MULT_XLEN{1'b0}}, a};
    b_s = {{`MULT_XLEN{b[`MULT_XLEN-1]}}, b};
    b_u = {{`MULT_XLEN{1'b0}}, b};
    case (op)
      mult_pkg::MULT_MUL: begin
        prod = a_s * b_s;
        res  = prod[`MULT_XLEN-1:0];
      end
      mult_pkg::MULT_MULH: begin
        prod = a_s * b_s;
        res  = prod[2*`MULT_XLEN-1:`MULT_XLEN];
      end
      mult_pkg::MULT_MULHU: begin
        prod = a_u * b_u;
        res  = prod[2*`MULT_XLEN-1:`MULT_XLEN];
      end
      mult_pkg::MULT_MULHSU: begin
        prod = a_s * b_u;
        res  = prod[2*`MULT_XLEN-1:`MULT_XLEN];
      end
      default: begin
        prod = {{96{a[31]}}, a[31:0]} * {{96{b[31]}}, b[31:0]};
        res  = {{32{prod[31]}}, prod[31:0]};
      end
    endcase
    return res;
  endfunction

  task automatic abort_run(string what);
    $display("%s", what);
    $display("TEST FAIL");
    $fatal(1, "simulation stopped");
  endtask

  // Advance to 1 ns after the next edge
  // A flush sampled at that edge empties the model
  task automatic next_cycle();
    @(posedge mult_clk);
    #1;
    if (flush) begin
      exp_q.delete();
    end
    flush     = 1'b0;
    issue_vld = 1'b0;
  endtask

  task automatic drive_issue();
    logic [31:0] rnd;
    rnd = next_rand();
    case (rnd[31:16] % 16'd5)
      16'd0:   issue_op = mult_pkg::MULT_MUL;
      16'd1:   issue_op = mult_pkg::MULT_MULH;
      16'd2:   issue_op = mult_pkg::MULT_MULHU;
      16'd3:   issue_op = mult_pkg::MULT_MULHSU;
      default: issue_op = mult_pkg::MULT_MULW;
    endcase
    issue_src0     = pick_operand();
    issue_src1     = pick_operand();
    issue_dst_preg = rnd[14:8];
    issue_vld      = 1'b1;
    exp_q.push_back(model_result(issue_op, issue_src0, issue_src1));
    issue_cnt = issue_cnt + 1;
  endtask

  task automatic wait_issue_slot();
    int cnt;
    cnt = 0;
    while (ex1_stall && cnt < 4) begin
      next_cycle();
      cnt = cnt + 1;
    end
    if (ex1_stall) begin
      abort_run("ex1_stall stayed high and no issue slot opened");
    end
  endtask

  task automatic wait_drain();
    int cnt;
    cnt = 0;
    while (exp_q.size() != 0 && cnt < 16) begin
      next_cycle();
      cnt = cnt + 1;
    end
    if (exp_q.size() != 0) begin
      abort_run("issued instructions never produced a result on ex4_data");
    end
  endtask

  // ------------------------------
  // Result check
  // ------------------------------
  task automatic check_result();
    mult_pkg::xlen_t exp_data;
    if (exp_q.size() == 0) begin
      abort_run("ex4_data_vld high with no instruction in flight");
    end else begin
      exp_data = exp_q.pop_front();
      assert (ex4_data === exp_data) else begin
        $display("** Error: ex4_data expected %h actual %h", exp_data, ex4_data);
        abort_run("wrong multiply result");
      end
    end
  endtask

  always @(negedge mult_clk) begin
    if (i_mult_unit.i_mult_unit_asserts.fail_cnt != 0) begin
      abort_run("a pipeline timing, tag, flush or reset check failed");
    end else if (cpurst_b && ex4_data_vld) begin
      check_result();
    end
  end

  initial begin
    logic [31:0] rnd;
    logic [15:0] choice;
    rng_state      = 32'h1717;
    issue_cnt      = 0;
    mult_clk       = 1'b0;
    cpurst_b       = 1'b0;
    issue_vld      = 1'b0;
    issue_op       = mult_pkg::MULT_MUL;
    issue_src0     = '0;
    issue_src1     = '0;
    issue_dst_preg = '0;
    flush          = 1'b0;
    repeat (3) @(posedge mult_clk);
    #1;
    cpurst_b = 1'b1;
    next_cycle();
    while (issue_cnt < 2000) begin
      rnd    = next_rand();
      choice = rnd[31:16] % 16'd100;
      if (choice < 16'd5) begin
        // Flush may also hit an instruction already in EX1
        flush = 1'b1;
        // Sometimes kill an instruction on its own issue edge
        if (choice < 16'd2 && !ex1_stall) begin
          drive_issue();
        end
      end else begin
        wait_issue_slot();
        if (choice >= 16'd10) begin
          drive_issue();
        end
      end
      next_cycle();
    end
    wait_drain();
    if (i_mult_unit.i_mult_unit_asserts.fail_cnt != 0) begin
      abort_run("a pipeline timing, tag, flush or reset check failed");
    end else begin
      $display("TEST PASS");
      $finish;
    end
  end

endmodule

//--- sources.f
+incdir+hdl
hdl/mult_pkg.sv
hdl/mult_issue_stage.sv
hdl/mult_booth_array.sv
hdl/mult_pipe_ctrl.sv
hdl/mult_result_sel.sv
hdl/mult_unit.sv
testbench/mult_unit_asserts.sv
testbench/mult_unit_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the mult_unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
  --top-module mult_unit_tb -f sources.f -o Vmult_unit_tb
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

# Let assertion errors reach the testbench instead of stopping at the first one
./obj_dir/Vmult_unit_tb +verilator+error+limit+100 > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "^TEST PASS$" "$LOG"; then
  echo "Simulation passed"
  exit 0
fi

echo "Simulation failed, exit status $run_status, see $LOG"
exit 1
